//--- tests/advtim_stimulus.txt
// columns, all hex: psc arr rcr ccr mode dtg brk exp_on
// mode 2 is pwm1, 3 is pwm2; exp_on is pwm_p active cycles over the whole run

// pwm1, no dead time
0000 0009 0001 0004 0002 0000 0000 0008
0001 0007 0002 0003 0002 0000 0000 0012

// pwm2, no dead time
0000 0009 0001 0004 0003 0000 0000 000c
0002 0004 0000 0001 0003 0000 0000 000c

// dead time on both edges
0000 000f 0001 0008 0002 0003 0000 000a
0001 0009 0002 0005 0003 0002 0000 0018

// break pulse during the run
0003 0009 0003 0005 0002 0000 0001 0000

// end marker
ffff 0000 0000 0000 0000 0000 0000 0000

//--- advtim.f
+incdir+source
source/advtim_pkg.sv
source/advtim_regs.sv
source/advtim_counter.sv
source/advtim_channel.sv
source/advtim_top.sv
tests/advtim_checker.sv
tests/advtim_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the advtim testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f advtim.f --top-module advtim_tb -o advtim_sim

status=0
./obj_dir/advtim_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation failed"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation passed"

//--- tests/advtim_tb.sv
// advtim testbench: table driven pwm runs over wishbone with duty, dead time and break checks
`timescale 1ns/1ps
`include "advtim_params.svh"

module advtim_tb;

localparam int MAX_ROWS = 16;
localparam int COLS     = 8;

logic         module_clk;
logic         module_rstn;
logic         wb_cyc;
logic         wb_stb;
logic         wb_we;
logic [7:0]   wb_adr;
logic [31:0]  wb_dat_w;
logic [31:0]  wb_dat_r;
logic         wb_ack;
logic         brk;
logic         pwm_p;
logic         pwm_n;
logic         int_line;

logic [15:0]  stim [0:MAX_ROWS*COLS-1];
int           errors;
int           timeouts;
int           wd_cycles;
logic         wd_armed;

// output monitor state
logic         measure;
logic         p_prev;
logic         n_prev;
int           on_cnt;
int           win_cnt;
int           idle_run;
int           cur_dtg;

advtim_top uut (.*);

bind advtim_top advtim_checker u_checker
(
	.module_clk  (module_clk),
	.module_rstn (module_rstn),
	.wb_ack      (wb_ack),
	.running     (running),
	.pwm_p       (pwm_p),
	.pwm_n       (pwm_n),
	.pol_p       (pol_p),
	.pol_n       (pol_n),
	.dtg         (dtg)
);

always #50 module_clk = ~module_clk;

task automatic report_mismatch(input string msg);
	$display("FAIL %0t: %s", $time, msg);
	errors++;
endtask

// ====================
// wishbone driver
// ====================

task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
	output logic [31:0] rdata);
	int wait_cnt;
	wait_cnt = 0;
	@(negedge module_clk);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = we;
	wb_adr   = adr;
	wb_dat_w = wdata;
	@(negedge module_clk);
	while (!wb_ack && wait_cnt < 8)
	begin
		@(negedge module_clk);
		wait_cnt++;
	end
	if (!wb_ack)
	begin
		$display("no acknowledge for bus access to %02h at %0t", adr, $time);
		timeouts++;
	end
	rdata = wb_dat_r;
	// keep stb up over the write edge
	@(negedge module_clk);
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
endtask

task automatic write_reg(input logic [7:0] adr, input logic [31:0] data);
	logic [31:0] discard;
	bus_access(1'b1, adr, data, discard);
endtask

task automatic read_reg(input logic [7:0] adr, output logic [31:0] data);
	bus_access(1'b0, adr, 32'h0, data);
endtask

task automatic check_readback(input logic [7:0] adr, input logic [31:0] mask,
	input logic [31:0] data);
	logic [31:0] rd;
	write_reg(adr, data);
	read_reg(adr, rd);
	if (rd != (data & mask))
		report_mismatch($sformatf("reg %02h read %08h, expected %08h", adr, rd, data & mask));
endtask

task automatic wait_int(input int limit, input string what);
	int n;
	n = 0;
	while (!int_line && n < limit)
	begin
		@(negedge module_clk);
		n++;
	end
	if (!int_line)
	begin
		$display("%s interrupt did not arrive within %0d cycles at %0t", what, limit, $time);
		timeouts++;
	end
endtask

// ====================
// output monitor
// ====================

always @(negedge module_clk)
begin
	if (measure)
	begin
		if (pwm_p)
			on_cnt = on_cnt + 1;
		if (pwm_p && !p_prev)
			win_cnt = win_cnt + 1;
		// any rising edge needs dtg idle cycles in front of it
		if ((pwm_p && !p_prev) || (pwm_n && !n_prev))
		begin
			if (idle_run < cur_dtg)
				report_mismatch($sformatf("dead time %0d, expected at least %0d",
					idle_run, cur_dtg));
		end
		if (!pwm_p && !pwm_n)
			idle_run = idle_run + 1;
		else
			idle_run = 0;
	end
	p_prev = pwm_p;
	n_prev = pwm_n;
end

// ====================
// test sequences
// ====================

task automatic run_row(input int row);
	int psc, arr, rcr, ccr, mode, dtg_v, brk_row, exp_on, per;
	logic [31:0] cfg;
	logic [31:0] rd;
	psc     = int'(stim[row*COLS]);
	arr     = int'(stim[row*COLS+1]);
	rcr     = int'(stim[row*COLS+2]);
	ccr     = int'(stim[row*COLS+3]);
	mode    = int'(stim[row*COLS+4]);
	dtg_v   = int'(stim[row*COLS+5]);
	brk_row = int'(stim[row*COLS+6]);
	exp_on  = int'(stim[row*COLS+7]);
	// pwm1 high below ccr, pwm2 the rest, dead time eats the front of each window
	per = (mode == 2) ? ccr * (psc + 1) : (arr + 1 - ccr) * (psc + 1);
	per = (per > dtg_v) ? per - dtg_v : 0;
	if (brk_row == 0 && per * (rcr + 1) != exp_on)
		report_mismatch($sformatf("row %0d table value %0d, duty rule gives %0d",
			row, exp_on, per * (rcr + 1)));
	cfg      = 32'h70;
	cfg[1:0] = mode[1:0];
	cfg[7]   = brk_row[0];
	cfg[8]   = brk_row[0];
	write_reg(`ADVTIM_ADDR_PSC, 32'(psc));
	write_reg(`ADVTIM_ADDR_ARR, 32'(arr));
	write_reg(`ADVTIM_ADDR_RCR, 32'(rcr));
	write_reg(`ADVTIM_ADDR_CCR, 32'(ccr));
	write_reg(`ADVTIM_ADDR_DTG, 32'(dtg_v));
	write_reg(`ADVTIM_ADDR_CHCFG, cfg);
	write_reg(`ADVTIM_ADDR_INT_EN, (brk_row != 0) ? 32'h4 : 32'h2);
	write_reg(`ADVTIM_ADDR_INT_STA, 32'h7);
	on_cnt   = 0;
	win_cnt  = 0;
	idle_run = 1000;
	cur_dtg  = dtg_v;
	measure  = (brk_row == 0);
	write_reg(`ADVTIM_ADDR_CTRL, 32'h1);
	if (brk_row != 0)
	begin
		repeat (20) @(negedge module_clk);
		brk = 1'b1;
		wait_int(10, "fault");
		brk = 1'b0;
		read_reg(`ADVTIM_ADDR_STATUS, rd);
		if (rd[0] != 1'b0)
			report_mismatch("still running after break");
		read_reg(`ADVTIM_ADDR_INT_STA, rd);
		if (rd[2] != 1'b1)
			report_mismatch("fault status bit not set");
		read_reg(`ADVTIM_ADDR_CHCFG, rd);
		if (rd[6] != 1'b0)
			report_mismatch("moe not cleared by break");
		if (pwm_p != 1'b0 || pwm_n != 1'b0)
			report_mismatch("outputs active after break");
		write_reg(`ADVTIM_ADDR_INT_STA, 32'h4);
		if (int_line != 1'b0)
			report_mismatch("int_line still high after fault clear");
		read_reg(`ADVTIM_ADDR_INT_STA, rd);
		if (rd[2] != 1'b0)
			report_mismatch("fault status bit not cleared");
	end
	else
	begin
		wait_int((psc + 1) * (arr + 1) * (rcr + 1) + 10, "end");
		measure = 1'b0;
		if (on_cnt != exp_on)
			report_mismatch($sformatf("row %0d pwm_p active %0d cycles, expected %0d",
				row, on_cnt, exp_on));
		if (win_cnt != rcr + 1)
			report_mismatch($sformatf("row %0d saw %0d windows, expected %0d",
				row, win_cnt, rcr + 1));
		read_reg(`ADVTIM_ADDR_STATUS, rd);
		if (rd[0] != 1'b0)
			report_mismatch("running still set after end interrupt");
		if (pwm_p != 1'b0 || pwm_n != 1'b0)
			report_mismatch("outputs active after end of run");
		// every run wraps at least once, so reload is flagged with end
		read_reg(`ADVTIM_ADDR_INT_STA, rd);
		if (rd[1:0] != 2'b11)
			report_mismatch($sformatf("row %0d INT_STA %08h, reload and end expected",
				row, rd));
	end
endtask

// force high with p active low, then clear
task automatic run_force();
	logic [31:0] rd;
	int n;
	int bad;
	bad = 0;
	write_reg(`ADVTIM_ADDR_PSC, 32'd0);
	write_reg(`ADVTIM_ADDR_ARR, 32'd99);
	write_reg(`ADVTIM_ADDR_RCR, 32'd0);
	write_reg(`ADVTIM_ADDR_DTG, 32'd0);
	write_reg(`ADVTIM_ADDR_CHCFG, 32'h75);
	write_reg(`ADVTIM_ADDR_CTRL, 32'h1);
	repeat (3) @(negedge module_clk);
	for (n = 0; n < 20; n++)
	begin
		if (pwm_p != 1'b0 || pwm_n != 1'b0)
			bad++;
		@(negedge module_clk);
	end
	if (bad != 0)
		report_mismatch($sformatf("force high gave wrong pin levels in %0d cycles", bad));
	write_reg(`ADVTIM_ADDR_CTRL, 32'h2);
	n = 0;
	while (pwm_p != 1'b1 && n < 2)
	begin
		@(negedge module_clk);
		n++;
	end
	if (pwm_p != 1'b1)
		report_mismatch("pwm_p still active two cycles after clear");
	read_reg(`ADVTIM_ADDR_STATUS, rd);
	if (rd[0] != 1'b0)
		report_mismatch("running still set after clear");
endtask

initial
begin
	int rows;
	int i;
	logic [31:0] rd;
	module_clk  = 1'b0;
	module_rstn = 1'b0;
	wb_cyc      = 1'b0;
	wb_stb      = 1'b0;
	wb_we       = 1'b0;
	wb_adr      = 8'h00;
	wb_dat_w    = 32'h0;
	brk         = 1'b0;
	measure     = 1'b0;
	p_prev      = 1'b0;
	n_prev      = 1'b0;
	errors      = 0;
	timeouts    = 0;
	wd_armed    = 1'b0;
	$readmemh("tests/advtim_stimulus.txt", stim);
	// row count up to the ffff marker, watchdog budget from the run lengths
	rows      = 0;
	wd_cycles = 2000;
	while (rows < MAX_ROWS && stim[rows*COLS] != 16'hFFFF)
	begin
		wd_cycles = wd_cycles + 200 + (int'(stim[rows*COLS]) + 1) *
			(int'(stim[rows*COLS+1]) + 1) * (int'(stim[rows*COLS+2]) + 1);
		rows++;
	end
	wd_armed = 1'b1;
	repeat (3) @(negedge module_clk);
	module_rstn = 1'b1;

	if (int_line != 1'b0 || wb_ack != 1'b0 || pwm_p != 1'b0 || pwm_n != 1'b0)
		report_mismatch("outputs not idle after reset");
	read_reg(`ADVTIM_ADDR_INT_STA, rd);
	if (rd != 32'h0)
		report_mismatch($sformatf("INT_STA %08h after reset", rd));
	read_reg(`ADVTIM_ADDR_STATUS, rd);
	if (rd[0] != 1'b0)
		report_mismatch("running set after reset");

	check_readback(`ADVTIM_ADDR_PSC, 32'h0000_FFFF, 32'hA5A5_5A5A);
	check_readback(`ADVTIM_ADDR_ARR, 32'h0000_FFFF, 32'h5A5A_A5A5);
	check_readback(`ADVTIM_ADDR_RCR, 32'h0000_00FF, 32'hA5A5_5A5A);
	check_readback(`ADVTIM_ADDR_CCR, 32'h0000_FFFF, 32'h5A5A_A5A5);
	check_readback(`ADVTIM_ADDR_CHCFG, 32'h0000_01FF, 32'hA5A5_5A5A);
	check_readback(`ADVTIM_ADDR_CHCFG, 32'h0000_01FF, 32'h5A5A_A5A5);
	check_readback(`ADVTIM_ADDR_DTG, 32'h0000_00FF, 32'h5A5A_A5A5);
	check_readback(`ADVTIM_ADDR_INT_EN, 32'h0000_0007, 32'hA5A5_5A5A);

	for (i = 0; i < rows; i++)
		run_row(i);
	run_force();

	$display("value errors %0d, timeouts %0d, assertion failures %0d",
		errors, timeouts, uut.u_checker.failures);
	if (errors == 0 && timeouts == 0 && uut.u_checker.failures == 0)
		$display("All tests passed");
	else
		$display("Some tests failed");
	$finish;
end

// watchdog
initial
begin
	wait (wd_armed);
	repeat (wd_cycles) @(posedge module_clk);
	$display("watchdog expired after %0d cycles, run stopped", wd_cycles);
	$display("Some tests failed");
	$finish;
end

endmodule

//--- tests/advtim_checker.sv
// advtim checker: bus handshake, reset state and complementary overlap assertions
`timescale 1ns/1ps
`include "advtim_params.svh"

module advtim_checker
(
	input  logic                      module_clk,
	input  logic                      module_rstn,
	input  logic                      wb_ack,
	input  logic                      running,
	input  logic                      pwm_p,
	input  logic                      pwm_n,
	input  logic                      pol_p,
	input  logic                      pol_n,
	input  logic [`ADVTIM_DTG_W-1:0]  dtg
);

int failures = 0;

// one wait state, so ack never lasts two cycles
ack_one_cycle: assert property (@(posedge module_clk) disable iff (!module_rstn)
	wb_ack |=> !wb_ack)
	else
	begin
		failures++;
		$error("wb_ack held for more than one cycle");
	end

run_idle_in_reset: assert property (@(posedge module_clk) !module_rstn |-> !running)
	else
	begin
		failures++;
		$error("running set while reset is asserted");
	end

// pin differs from polarity means the output is active
no_overlap: assert property (@(posedge module_clk) disable iff (!module_rstn)
	(dtg != '0) |-> !((pwm_p != pol_p) && (pwm_n != pol_n)))
	else
	begin
		failures++;
		$error("pwm_p and pwm_n active together with dead time set");
	end

endmodule

//--- source/advtim_top.sv
// advtim top: wishbone controlled complementary pwm pair with dead time and break
`timescale 1ns/1ps
`include "advtim_params.svh"

module advtim_top
	import advtim_pkg::*;
(
	input  logic         module_clk,
	input  logic         module_rstn,
	input  logic         wb_cyc,
	input  logic         wb_stb,
	input  logic         wb_we,
	input  logic [7:0]   wb_adr,
	input  logic [31:0]  wb_dat_w,
	output logic [31:0]  wb_dat_r,
	output logic         wb_ack,
	input  logic         brk,
	output logic         pwm_p,
	output logic         pwm_n,
	output logic         int_line
);

// regs to counter and channel
logic                      start_pulse;
logic                      clear_pulse;
logic [`ADVTIM_CNT_W-1:0]  psc;
logic [`ADVTIM_CNT_W-1:0]  arr;
logic [`ADVTIM_RCR_W-1:0]  rcr;
logic [`ADVTIM_CNT_W-1:0]  ccr;
oc_mode_t                  mode;
logic                      pol_p;
logic                      pol_n;
logic                      en_p;
logic                      en_n;
logic                      moe;
logic                      bke;
logic                      bkp;
logic [`ADVTIM_DTG_W-1:0]  dtg;

// counter and channel events
logic [`ADVTIM_CNT_W-1:0]  cnt;
logic                      update;
logic                      end_evt;
logic                      running;
logic                      fault;

// ====================
// stages
// ====================

advtim_regs u_regs (.*);

advtim_counter u_counter (.*);

advtim_channel u_channel (.*);

endmodule

//--- source/advtim_channel.sv
// advtim channel: compare, output mode, dead time, break input and pin polarity
`timescale 1ns/1ps
`include "advtim_params.svh"

module advtim_channel
	import advtim_pkg::*;
(
	input  logic                      module_clk,
	input  logic                      module_rstn,
	input  logic [`ADVTIM_CNT_W-1:0]  cnt,
	input  logic                      running,
	input  logic [`ADVTIM_CNT_W-1:0]  ccr,
	input  oc_mode_t                  mode,
	input  logic                      pol_p,
	input  logic                      pol_n,
	input  logic                      en_p,
	input  logic                      en_n,
	input  logic                      moe,
	input  logic                      bke,
	input  logic                      bkp,
	input  logic [`ADVTIM_DTG_W-1:0]  dtg,
	input  logic                      brk,
	output logic                      pwm_p,
	output logic                      pwm_n,
	output logic                      fault
);

logic [1:0]                brk_sync;
logic                      brk_act;
logic                      run_q;
logic                      ref_d;
logic                      ref_q;
logic                      gate;
logic                      p_ideal;
logic                      n_ideal;
logic                      p_on;
logic                      n_on;
logic [`ADVTIM_DTG_W-1:0]  dt_p;
logic [`ADVTIM_DTG_W-1:0]  dt_n;

// ====================
// break input
// ====================

always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
		brk_sync <= 2'b00;
	else
		brk_sync <= {brk_sync[0], brk};
end

// bkp set means the pin is active high
assign brk_act = bke && (brk_sync[1] == bkp);
// moe drops next cycle, so this is a single pulse
assign fault   = brk_act & moe;

// ====================
// reference level
// ====================

always_comb
begin
	unique case (mode)
		OC_FORCE_LOW:  ref_d = 1'b0;
		OC_FORCE_HIGH: ref_d = 1'b1;
		OC_PWM1:       ref_d = (cnt < ccr);
		OC_PWM2:       ref_d = ~(cnt < ccr);
		default:       ref_d = 1'b0;
	endcase
end

// running delayed with it to stay aligned with the count
always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
	begin
		ref_q <= 1'b0;
		run_q <= 1'b0;
	end
	else
	begin
		ref_q <= ref_d;
		run_q <= running;
	end
end

// ====================
// complementary pair and dead time
// ====================

assign gate    = run_q & moe & ~brk_act;
assign p_ideal = ref_q & en_p & gate;
assign n_ideal = ~ref_q & en_n & gate;

// counter reloads while its output is idle, counts down once requested
always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
	begin
		dt_p <= '0;
		dt_n <= '0;
	end
	else
	begin
		if (!p_ideal)
			dt_p <= dtg;
		else if (dt_p != '0)
			dt_p <= dt_p - 1'b1;
		if (!n_ideal)
			dt_n <= dtg;
		else if (dt_n != '0)
			dt_n <= dt_n - 1'b1;
	end
end

assign p_on = p_ideal && (dt_p == '0);
assign n_on = n_ideal && (dt_n == '0);

// pin level, pol set means active low
assign pwm_p = p_on ^ pol_p;
assign pwm_n = n_on ^ pol_n;

endmodule

//--- source/advtim_counter.sv
// advtim counter: run control, prescaler, up counter and repetition counter
`timescale 1ns/1ps
`include "advtim_params.svh"

module advtim_counter
(
	input  logic                      module_clk,
	input  logic                      module_rstn,
	input  logic                      start_pulse,
	input  logic                      clear_pulse,
	input  logic                      fault,
	input  logic [`ADVTIM_CNT_W-1:0]  psc,
	input  logic [`ADVTIM_CNT_W-1:0]  arr,
	input  logic [`ADVTIM_RCR_W-1:0]  rcr,
	output logic [`ADVTIM_CNT_W-1:0]  cnt,
	output logic                      update,
	output logic                      end_evt,
	output logic                      running
);

logic [`ADVTIM_CNT_W-1:0]  psc_a;
logic [`ADVTIM_CNT_W-1:0]  arr_a;
logic [`ADVTIM_CNT_W-1:0]  psc_cnt;
logic [`ADVTIM_RCR_W-1:0]  rep_cnt;
logic                      start_pend;
logic                      start_go;
logic                      stop;
logic                      tick;
logic                      wrap;
logic                      last;

// ====================
// run control
// ====================

assign stop     = clear_pulse | fault;
assign start_go = (start_pulse | start_pend) & ~running & ~stop;

// start together with clear means restart, hold the start one cycle
always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
		start_pend <= 1'b0;
	else if (fault)
		start_pend <= 1'b0;
	else if (start_pulse && clear_pulse)
		start_pend <= 1'b1;
	else if (start_go)
		start_pend <= 1'b0;
end

always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
		running <= 1'b0;
	else if (last || stop)
		running <= 1'b0;
	else if (start_go)
		running <= 1'b1;
end

// ====================
// counting
// ====================

assign tick = running && (psc_cnt == psc_a);
assign wrap = tick && (cnt == arr_a);
assign last = wrap && (rep_cnt == '0);

// active copies, refreshed at start and on every wrap
always_ff @(posedge module_clk)
begin
	if (start_go || wrap)
	begin
		psc_a <= psc;
		arr_a <= arr;
	end
end

always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
	begin
		psc_cnt <= '0;
		cnt     <= '0;
		rep_cnt <= '0;
	end
	else if (start_go || stop)
	begin
		psc_cnt <= '0;
		cnt     <= '0;
		rep_cnt <= rcr;
	end
	else if (running)
	begin
		psc_cnt <= tick ? '0 : psc_cnt + 1'b1;
		if (tick)
			cnt <= wrap ? '0 : cnt + 1'b1;
		if (wrap && (rep_cnt != '0))
			rep_cnt <= rep_cnt - 1'b1;
	end
end

// events line up with the running drop
always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
	begin
		update  <= 1'b0;
		end_evt <= 1'b0;
	end
	else
	begin
		update  <= wrap;
		end_evt <= last;
	end
end

endmodule

//--- source/advtim_regs.sv
// advtim register file: wishbone slave, shadow registers, run pulses and interrupt status
`timescale 1ns/1ps
`include "advtim_params.svh"

module advtim_regs
	import advtim_pkg::*;
(
	input  logic                      module_clk,
	input  logic                      module_rstn,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  logic [7:0]                wb_adr,
	input  logic [31:0]               wb_dat_w,
	output logic [31:0]               wb_dat_r,
	output logic                      wb_ack,
	input  logic                      running,
	input  logic [`ADVTIM_CNT_W-1:0]  cnt,
	input  logic                      update,
	input  logic                      end_evt,
	input  logic                      fault,
	output logic                      start_pulse,
	output logic                      clear_pulse,
	output logic [`ADVTIM_CNT_W-1:0]  psc,
	output logic [`ADVTIM_CNT_W-1:0]  arr,
	output logic [`ADVTIM_RCR_W-1:0]  rcr,
	output logic [`ADVTIM_CNT_W-1:0]  ccr,
	output oc_mode_t                  mode,
	output logic                      pol_p,
	output logic                      pol_n,
	output logic                      en_p,
	output logic                      en_n,
	output logic                      moe,
	output logic                      bke,
	output logic                      bkp,
	output logic [`ADVTIM_DTG_W-1:0]  dtg,
	output logic                      int_line
);

logic                          wr;
logic [`ADVTIM_CHCFG_W-1:0]    chcfg;
logic [`ADVTIM_NUM_INT-1:0]    int_en;
logic [`ADVTIM_NUM_INT-1:0]    int_sta;
logic [`ADVTIM_NUM_INT-1:0]    int_set;
logic [`ADVTIM_NUM_INT-1:0]    int_clr;

// ====================
// wishbone handshake
// ====================

// one wait state, ack for a single cycle
always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
		wb_ack <= 1'b0;
	else
		wb_ack <= wb_cyc & wb_stb & ~wb_ack;
end

// write lands in the ack cycle
assign wr = wb_cyc & wb_stb & wb_ack & wb_we;

// CTRL bits are self clearing pulses
assign start_pulse = wr && (wb_adr == `ADVTIM_ADDR_CTRL) && wb_dat_w[0];
assign clear_pulse = wr && (wb_adr == `ADVTIM_ADDR_CTRL) && wb_dat_w[1];

// ====================
// shadow registers
// ====================

always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
	begin
		psc    <= `ADVTIM_PSC_RST;
		arr    <= `ADVTIM_ARR_RST;
		rcr    <= `ADVTIM_RCR_RST;
		ccr    <= `ADVTIM_CCR_RST;
		chcfg  <= `ADVTIM_CHCFG_RST;
		dtg    <= `ADVTIM_DTG_RST;
		int_en <= '0;
	end
	else
	begin
		if (wr)
		begin
			case (wb_adr)
				`ADVTIM_ADDR_PSC:    psc    <= wb_dat_w[`ADVTIM_CNT_W-1:0];
				`ADVTIM_ADDR_ARR:    arr    <= wb_dat_w[`ADVTIM_CNT_W-1:0];
				`ADVTIM_ADDR_RCR:    rcr    <= wb_dat_w[`ADVTIM_RCR_W-1:0];
				`ADVTIM_ADDR_CCR:    ccr    <= wb_dat_w[`ADVTIM_CNT_W-1:0];
				`ADVTIM_ADDR_CHCFG:  chcfg  <= wb_dat_w[`ADVTIM_CHCFG_W-1:0];
				`ADVTIM_ADDR_DTG:    dtg    <= wb_dat_w[`ADVTIM_DTG_W-1:0];
				`ADVTIM_ADDR_INT_EN: int_en <= wb_dat_w[`ADVTIM_NUM_INT-1:0];
				default: ;
			endcase
		end
		// break kills moe, software has to set it again
		if (fault)
			chcfg[6] <= 1'b0;
	end
end

assign mode  = oc_mode_t'(chcfg[1:0]);
assign pol_p = chcfg[2];
assign pol_n = chcfg[3];
assign en_p  = chcfg[4];
assign en_n  = chcfg[5];
assign moe   = chcfg[6];
assign bke   = chcfg[7];
assign bkp   = chcfg[8];

// ====================
// interrupt status
// ====================

always_comb
begin
	int_set = '0;
	int_set[INT_RELOAD] = update;
	int_set[INT_END]    = end_evt;
	int_set[INT_FAULT]  = fault;
end

assign int_clr = (wr && (wb_adr == `ADVTIM_ADDR_INT_STA)) ?
	wb_dat_w[`ADVTIM_NUM_INT-1:0] : '0;

// new event wins over a clear in the same cycle
always_ff @(posedge module_clk or negedge module_rstn)
begin
	if (!module_rstn)
		int_sta <= '0;
	else
		int_sta <= (int_sta & ~int_clr) | int_set;
end

assign int_line = |(int_sta & int_en);

// read mux
always_comb
begin
	wb_dat_r = '0;
	case (wb_adr)
		`ADVTIM_ADDR_PSC:     wb_dat_r[`ADVTIM_CNT_W-1:0]   = psc;
		`ADVTIM_ADDR_ARR:     wb_dat_r[`ADVTIM_CNT_W-1:0]   = arr;
		`ADVTIM_ADDR_RCR:     wb_dat_r[`ADVTIM_RCR_W-1:0]   = rcr;
		`ADVTIM_ADDR_CCR:     wb_dat_r[`ADVTIM_CNT_W-1:0]   = ccr;
		`ADVTIM_ADDR_CHCFG:   wb_dat_r[`ADVTIM_CHCFG_W-1:0] = chcfg;
		`ADVTIM_ADDR_DTG:     wb_dat_r[`ADVTIM_DTG_W-1:0]   = dtg;
		`ADVTIM_ADDR_INT_EN:  wb_dat_r[`ADVTIM_NUM_INT-1:0] = int_en;
		`ADVTIM_ADDR_INT_STA: wb_dat_r[`ADVTIM_NUM_INT-1:0] = int_sta;
		`ADVTIM_ADDR_STATUS:
		begin
			wb_dat_r[0]     = running;
			wb_dat_r[31:16] = cnt;
		end
		default: ;
	endcase
end

endmodule

//--- source/advtim_pkg.sv
// advtim package: output-compare modes and interrupt cause bit positions
package advtim_pkg;

// ====================
// output compare
// ====================

// source of the channel reference level
typedef enum logic [1:0] {
	OC_FORCE_LOW  = 2'd0,
	OC_FORCE_HIGH = 2'd1,
	OC_PWM1       = 2'd2,
	OC_PWM2       = 2'd3
} oc_mode_t;

// ====================
// interrupts
// ====================

// bit index inside INT_EN and INT_STA
typedef enum logic [1:0] {
	INT_RELOAD = 2'd0,
	INT_END    = 2'd1,
	INT_FAULT  = 2'd2
} int_cause_t;

endpackage

//--- source/advtim_params.svh
// advtim parameters: register map, field widths and register reset values
`ifndef ADVTIM_PARAMS_SVH
`define ADVTIM_PARAMS_SVH

// field widths
`define ADVTIM_CNT_W        16
`define ADVTIM_RCR_W        8
`define ADVTIM_DTG_W        8
`define ADVTIM_CHCFG_W      9
`define ADVTIM_NUM_INT      3

// register word addresses
`define ADVTIM_ADDR_CTRL    8'h00
`define ADVTIM_ADDR_PSC     8'h04
`define ADVTIM_ADDR_ARR     8'h08
`define ADVTIM_ADDR_RCR     8'h0C
`define ADVTIM_ADDR_CCR     8'h10
`define ADVTIM_ADDR_CHCFG   8'h14
`define ADVTIM_ADDR_DTG     8'h18
`define ADVTIM_ADDR_INT_EN  8'h1C
`define ADVTIM_ADDR_INT_STA 8'h20
`define ADVTIM_ADDR_STATUS  8'h24

// reset values, outputs idle and moe off
`define ADVTIM_PSC_RST      16'h0000
`define ADVTIM_ARR_RST      16'hFFFF
`define ADVTIM_RCR_RST      8'h00
`define ADVTIM_CCR_RST      16'h0000
`define ADVTIM_CHCFG_RST    9'h000
`define ADVTIM_DTG_RST      8'h00

`endif
